//--- gain_multiplier.sv
// gain multiplier
// one register stage that multiplies each Q1.15 sample by a Q1.15 gain,
// clamps the single overflowing product and keeps a Q1.30 result
// together with the last flag and the rounding mode
module gain_multiplier (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  scale_pkg::in_beat_t    i_in,
  input  logic                   i_in_valid,
  output logic                   o_in_ready,
  input  scale_pkg::sample_t     i_gain,
  input  scale_pkg::round_mode_e i_round_mode,
  output scale_pkg::wide_beat_t  o_prod,
  output logic                   o_prod_valid,
  input  logic                   i_prod_ready
);
  import scale_pkg::*;

  localparam int SAMPLE_W = $bits(sample_t);
  localparam int FULL_W   = 2 * SAMPLE_W;  // Q2.30
  localparam int WIDE_W   = $bits(wide_t);

  logic signed [FULL_W-1:0] full_prod;
  logic                     overflow;
  wide_t                    clamped;
  logic                     in_fire;

  // signed by signed, both operands are sample_t
  assign full_prod = i_in.data * i_gain;

  // only -1 * -1 lands here, the two top bits then disagree
  assign overflow = full_prod[FULL_W-1] ^ full_prod[FULL_W-2];

  always_comb begin
    if (overflow) begin
      clamped = {1'b0, {(WIDE_W-1){1'b1}}}; // largest positive Q1.30
    end else begin
      clamped = full_prod[WIDE_W-1:0];
    end
  end

  // stage can take a beat when empty or when its beat leaves this cycle
  assign o_in_ready = ~o_prod_valid | i_prod_ready;
  assign in_fire    = i_in_valid & o_in_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_prod_valid <= 1'b0;
    end else if (o_in_ready) begin
      o_prod_valid <= i_in_valid;
    end
  end

  // gain and mode are sampled with the beat they apply to
  always_ff @(posedge i_clk) begin
    if (in_fire) begin
      o_prod.data <= clamped;
      o_prod.last <= i_in.last;
      o_prod.mode <= i_round_mode;
    end
  end

endmodule

//--- sample_fifo.sv
// sample FIFO
// circular buffer with a registered output beat, valid/ready on both sides
// the output register is refilled from storage, or straight from the
// input when the storage is empty
`include "scale_config.svh"

module sample_fifo #(
  parameter int DEPTH = `SCALE_FIFO_DEPTH
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  scale_pkg::out_beat_t i_wr,
  input  logic                 i_wr_valid,
  output logic                 o_wr_ready,
  output scale_pkg::out_beat_t o_rd,
  output logic                 o_rd_valid,
  input  logic                 i_rd_ready
);
  import scale_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  out_beat_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held in storage
  logic             wr_fire;
  logic             rd_fire;
  logic             load_out;
  logic             bypass;
  logic             push;
  logic             pop;

  assign o_wr_ready = (count != CNT_W'(DEPTH));
  assign wr_fire    = i_wr_valid & o_wr_ready;
  assign rd_fire    = o_rd_valid & i_rd_ready;

  // output register is free or empties on this edge
  assign load_out = ~o_rd_valid | rd_fire;

  // oldest stored entry has priority over the incoming beat
  assign pop    = load_out & (count != '0);
  assign bypass = load_out & (count == '0) & wr_fire;
  assign push   = wr_fire & ~bypass;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (load_out) begin
        o_rd_valid <= pop | bypass;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_wr;
    end
    if (pop) begin
      o_rd <= mem[rd_ptr];
    end else if (bypass) begin
      o_rd <= i_wr;  // empty storage, skip it
    end
  end

endmodule

//--- sample_rounder.sv
// sample rounder
// cuts each Q1.30 product back to a Q1.15 sample with the rounding mode
// carried in its beat, then buffers the result for the output stream
`include "scale_config.svh"

module sample_rounder #(
  parameter int FIFO_DEPTH = `SCALE_FIFO_DEPTH
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  scale_pkg::wide_beat_t i_prod,
  input  logic                  i_prod_valid,
  output logic                  o_prod_ready,
  output scale_pkg::out_beat_t  o_out,
  output logic                  o_out_valid,
  input  logic                  i_out_ready
);
  import scale_pkg::*;

  localparam int WIDE_W = `SCALE_WIDE_W;
  localparam int OUT_W  = `SCALE_SAMPLE_W;
  localparam int FRAC_W = WIDE_W - OUT_W;  // bits dropped by the cut

  wide_t     prod;
  sample_t   high_part;
  logic      max_pos;
  logic      corr_nearest;
  logic      corr_zero;
  logic      round_corr;
  out_beat_t rounded;

  assign prod      = i_prod.data;
  assign high_part = prod[WIDE_W-1 -: OUT_W];  // bits 30 down to 15

  // positive with every kept magnitude bit set, rounding up would wrap
  assign max_pos = ~prod[WIDE_W-1] & (&prod[WIDE_W-2:FRAC_W]);

  assign corr_nearest = prod[FRAC_W-1];  // half an lsb or more
  assign corr_zero    = prod[WIDE_W-1] & (|prod[FRAC_W-1:0]);

  always_comb begin
    case (i_prod.mode)
      ROUND_NEAREST: round_corr = max_pos ? 1'b0 : corr_nearest;
      ROUND_ZERO:    round_corr = corr_zero;
      default:       round_corr = 1'b0;  // truncate
    endcase
  end

  // correction is zero extended before the add
  assign rounded.data = high_part + sample_t'(round_corr);
  assign rounded.last = i_prod.last;

  // beat is written into the buffer on the edge it is accepted
  sample_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_sample_fifo (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_wr       (rounded),
    .i_wr_valid (i_prod_valid),
    .o_wr_ready (o_prod_ready),
    .o_rd       (o_out),
    .o_rd_valid (o_out_valid),
    .i_rd_ready (i_out_ready)
  );

endmodule

//--- scale_config.svh
// scale stage configuration
// widths of the samples, gains and clamped products,
// plus the default depth of the output buffer
`ifndef SCALE_CONFIG_SVH
`define SCALE_CONFIG_SVH

// Q1.15 sample and gain width
`define SCALE_SAMPLE_W 16

// Q1.30 product width after the clamp
// the sign bit of the full Q2.30 product is dropped
`define SCALE_WIDE_W 31

// entries in the output buffer storage
// any power of two of 2 or more
`define SCALE_FIFO_DEPTH 4

`endif

//--- scale_pkg.sv
// scale stage types
// sample and product words, rounding modes and the stream beats
// that travel between the producer, the rounder and the outside
`include "scale_config.svh"

package scale_pkg;

  typedef logic signed [`SCALE_SAMPLE_W-1:0] sample_t; // Q1.15
  typedef logic signed [`SCALE_WIDE_W-1:0]   wide_t;   // Q1.30

  // rounding applied when a product is cut back to a sample
  typedef enum logic [1:0] {
    ROUND_NEAREST = 2'd0, // nearest, never wraps the largest value
    ROUND_TRUNC   = 2'd1, // toward minus infinity
    ROUND_ZERO    = 2'd2  // toward zero
  } round_mode_e;

  typedef struct packed {
    sample_t data;
    logic    last;
  } in_beat_t;

  // product beat carries the mode that was in effect at acceptance
  typedef struct packed {
    wide_t       data;
    logic        last;
    round_mode_e mode;
  } wide_beat_t;

  typedef struct packed {
    sample_t data;
    logic    last;
  } out_beat_t;

endpackage

//--- scale_round_checker.sv
// scale and round protocol checker
// valid/ready rules on the output stream and on the buffer input stream,
// bound to the top level
module scale_round_checker (
  input logic                  i_clk,
  input logic                  i_reset,
  input scale_pkg::out_beat_t  i_out,
  input logic                  i_out_valid,
  input logic                  i_out_ready,
  input scale_pkg::wide_beat_t i_prod,
  input logic                  i_prod_valid,
  input logic                  i_prod_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // assertions that have failed so far

  task automatic report_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // a reset edge always leaves both streams empty
  a_out_reset_low: assert property (@(posedge i_clk) i_reset |=> !i_out_valid)
    else report_failure("output valid high after a reset cycle");
  a_prod_reset_low: assert property (@(posedge i_clk) i_reset |=> !i_prod_valid)
    else report_failure("buffer input valid high after a reset cycle");

  // a stalled beat is held unchanged until it transfers
  a_out_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_out_valid && !i_out_ready |=> $stable(i_out))
    else report_failure("output beat changed while stalled");
  a_out_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_out_valid && !i_out_ready |=> i_out_valid)
    else report_failure("output valid dropped before a transfer");

  a_prod_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_prod_valid && !i_prod_ready |=> $stable(i_prod))
    else report_failure("buffer input beat changed while stalled");
  a_prod_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_prod_valid && !i_prod_ready |=> i_prod_valid)
    else report_failure("buffer input valid dropped before a transfer");

endmodule

bind scale_round_top scale_round_checker u_checker (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_out        (o_out),
  .i_out_valid  (o_out_valid),
  .i_out_ready  (i_out_ready),
  .i_prod       (prod),
  .i_prod_valid (prod_valid),
  .i_prod_ready (prod_ready)
);

//--- scale_round_top.sv
// scale and round top level
// gain multiplier stage feeding the rounder and its output buffer,
// two cycles from input acceptance to the output transfer
module scale_round_top (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  scale_pkg::in_beat_t    i_in,
  input  logic                   i_in_valid,
  output logic                   o_in_ready,
  input  scale_pkg::sample_t     i_gain,
  input  scale_pkg::round_mode_e i_round_mode,
  output scale_pkg::out_beat_t   o_out,
  output logic                   o_out_valid,
  input  logic                   i_out_ready
);
  import scale_pkg::*;

  wide_beat_t prod;        // product stream between the stages
  logic       prod_valid;
  logic       prod_ready;

  gain_multiplier u_gain_multiplier (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_in         (i_in),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .i_gain       (i_gain),
    .i_round_mode (i_round_mode),
    .o_prod       (prod),
    .o_prod_valid (prod_valid),
    .i_prod_ready (prod_ready)
  );

  sample_rounder u_sample_rounder (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_prod       (prod),
    .i_prod_valid (prod_valid),
    .o_prod_ready (prod_ready),
    .o_out        (o_out),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready)
  );

endmodule

//--- tb_scale_round.sv
// testbench for the scale and round stage
// directed tests against a model of the clamp and rounding rules,
// a monitor checks every output beat against a queue of expected beats
module tb_scale_round;
  timeunit 1ns;
  timeprecision 100ps;
  import scale_pkg::*;

  localparam int N_NEAREST      = 200;
  localparam int N_DIRECTED     = 14;
  localparam int N_MIXED        = 60;
  localparam int N_STALL        = 150;
  localparam int TOTAL_BEATS    = N_NEAREST + N_DIRECTED + N_MIXED + N_STALL;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 100;

  logic        clk;
  logic        reset;
  in_beat_t    in_beat;
  logic        in_valid;
  logic        in_ready;
  sample_t     gain;
  round_mode_e round_mode;
  out_beat_t   out_beat;
  logic        out_valid;
  logic        out_ready;

  out_beat_t exp_q[$];   // expected output beats in order
  out_beat_t mon_exp;
  int        errors = 0;
  int        checks = 0;
  int        in_count = 0;
  int        out_count = 0;
  int        cycle = 0;
  int        last_acc_cyc = 0;  // negedge count before the last input transfer
  int        last_out_cyc = 0;

  scale_round_top DUT (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_in         (in_beat),
    .i_in_valid   (in_valid),
    .o_in_ready   (in_ready),
    .i_gain       (gain),
    .i_round_mode (round_mode),
    .o_out        (out_beat),
    .o_out_valid  (out_valid),
    .i_out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  // Q1.15 times Q1.15, clamp to Q1.30, then cut to Q1.15 with the mode's rule
  function automatic sample_t model_round(input sample_t s, input sample_t g,
                                          input round_mode_e m);
    longint p;
    longint q;
    longint r;
    p = longint'(s) * longint'(g);
    if (p > 64'sh3FFF_FFFF) p = 64'sh3FFF_FFFF;  // only -1 * -1
    q = p >>> 15;            // floor
    r = p - (q <<< 15);      // dropped fraction, 0 to 32767
    case (m)
      ROUND_NEAREST: if (r >= 16384 && q < 32767) q = q + 1;
      ROUND_ZERO:    if (p < 0 && r != 0) q = q + 1;
      default:       q = q;
    endcase
    return sample_t'(q);
  endfunction

  // output side, sampled half a cycle before the transfer edge
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output beat 0x%0h arrived while no beat was expected", out_beat.data);
      end else begin
        mon_exp = exp_q.pop_front();
        check_value("o_out.data", out_beat.data, mon_exp.data);
        check_value("o_out.last", out_beat.last, mon_exp.last);
      end
      out_count++;
      last_out_cyc = cycle;
    end
  end

  // holds reset for 5 edges, called at time 0 or right after a rising edge
  task automatic apply_reset();
    reset    <= 1'b1;
    in_valid <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) reset <= 1'b0;
      @(negedge clk);
      check_value("o_out_valid", out_valid, 1'b0);
    end
    check_value("o_in_ready", in_ready, 1'b1);
  endtask

  // called right after a rising edge, returns at the edge that accepts the beat
  task automatic push_exp(input sample_t s, input sample_t g, input round_mode_e m,
                          input logic last, input sample_t exp_data);
    out_beat_t e;
    in_beat.data <= s;
    in_beat.last <= last;
    in_valid     <= 1'b1;
    gain         <= g;
    round_mode   <= m;
    e.data = exp_data;
    e.last = last;
    exp_q.push_back(e);
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    last_acc_cyc = cycle;
    in_count++;
    @(posedge clk);
  endtask

  task automatic push_model(input sample_t s, input sample_t g, input round_mode_e m,
                            input logic last);
    push_exp(s, g, m, last, model_round(s, g, m));
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    check_value("output beat count", out_count, in_count);
  endtask

  task automatic test_nearest_random();
    @(posedge clk);
    for (int i = 0; i < N_NEAREST; i++) begin
      push_model(sample_t'($urandom()), sample_t'($urandom()), ROUND_NEAREST,
                 1'($urandom() % 2));
    end
    drain();
  endtask

  // same product in both modes, negatives differ by one lsb
  task automatic push_pair(input sample_t s, input sample_t g,
                           input sample_t exp_trunc, input sample_t exp_zero);
    push_exp(s, g, ROUND_TRUNC, 1'b0, exp_trunc);
    push_exp(s, g, ROUND_ZERO, 1'b1, exp_zero);
  endtask

  task automatic test_trunc_zero();
    @(posedge clk);
    push_pair(-16'sd3, 16'sh4000, 16'shFFFE, 16'shFFFF);     // -1.5 lsb
    push_pair(16'sd3, 16'sh4000, 16'sh0001, 16'sh0001);      // +1.5 lsb
    push_pair(-16'sd5, 16'sh2000, 16'shFFFE, 16'shFFFF);     // -1.25 lsb
    push_pair(16'sh1234, 16'sh7FFF, 16'sh1233, 16'sh1233);
    push_pair(16'shEDCC, 16'sh7FFF, 16'shEDCC, 16'shEDCD);
    drain();
  endtask

  task automatic test_safe_rounding();
    @(posedge clk);
    // clamped -1 * -1, bit 14 set with bits 29 to 15 all ones
    push_exp(16'sh8000, 16'sh8000, ROUND_NEAREST, 1'b0, 16'sh7FFF);
    push_exp(16'sh8000, 16'sh8001, ROUND_NEAREST, 1'b0, 16'sh7FFF); // 0x3FFF8000
    push_exp(16'sh7FFF, 16'sh7FFF, ROUND_NEAREST, 1'b1, 16'sh7FFE);
    drain();
  endtask

  task automatic test_mode_gain_change();
    @(posedge clk);
    for (int i = 0; i < N_MIXED; i++) begin
      push_model(sample_t'($urandom()), sample_t'($urandom()), round_mode_e'(i % 3),
                 1'(i % 5 == 4));
    end
    drain();
  endtask

  task automatic test_backpressure();
    logic saw_stall;
    logic stim_done;
    saw_stall = 1'b0;
    stim_done = 1'b0;
    @(posedge clk);
    fork
      begin
        for (int i = 0; i < N_STALL; i++) begin
          push_model(sample_t'($urandom()), sample_t'($urandom()),
                     round_mode_e'($urandom() % 3), 1'($urandom() % 2));
        end
        in_valid <= 1'b0;
        stim_done = 1'b1;
      end
      begin
        out_ready <= 1'b0;  // long stall fills the buffer
        repeat (20) begin
          @(negedge clk);
          if (!in_ready) saw_stall = 1'b1;
        end
        while (!stim_done) begin
          @(posedge clk);
          out_ready <= ($urandom() % 4) != 0;
        end
        out_ready <= 1'b1;
      end
    join
    check_value("o_in_ready fell under stall", saw_stall, 1'b1);
    drain();
  endtask

  task automatic test_latency();
    apply_reset();
    @(posedge clk);
    push_model(16'sh4000, 16'sh4000, ROUND_NEAREST, 1'b1);
    drain();
    check_value("latency in cycles", last_out_cyc - last_acc_cyc, 2);
  endtask

  initial begin
    void'($urandom(19105));
    reset      = 1'b1;
    in_beat    = '0;
    in_valid   = 1'b0;
    gain       = '0;
    round_mode = ROUND_NEAREST;
    out_ready  = 1'b1;
    apply_reset();
    test_nearest_random();
    test_trunc_zero();
    test_safe_rounding();
    test_mode_gain_change();
    test_backpressure();
    test_latency();
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             DUT.u_checker.fail_count);
    if (errors == 0 && DUT.u_checker.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog, about 20 cycles per beat plus room for the resets
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
scale_pkg.sv
gain_multiplier.sv
sample_fifo.sv
sample_rounder.sv
scale_round_top.sv
scale_round_checker.sv
tb_scale_round.sv
